// File: dv/core_tb.sv
// core_tb: clock, reset, LFSR, memory and loader models, stimulus, assertions, timeout
`include "core_defines.svh"

module core_tb;

	localparam int LOADER_MIN_DELAY = 3;
	localparam int LOADER_MAX_DELAY = LOADER_MIN_DELAY + 15;
	localparam int SAMPLES_TO_CHECK = 8;
	localparam int UPDATES_TO_SEE   = 3;
	localparam int FIRST_REQUEST    = (`CORE_PLAY_DELAY + 1) * `CORE_AUDIO_PERIOD;
	localparam int TIMEOUT_CYCLES   = 2 * (16 + LOADER_MAX_DELAY + 4 * (4 + 2)
		+ 3 * `CORE_UPDATE_PERIOD + 20 * `CORE_AUDIO_PERIOD);

	logic                    CLK;
	logic                    RESET_L;
	logic                    song_reset_done;
	logic                    song_restart;
	core_pkg::beatmap_addr_t beatmap_addr;
	logic                    beatmap_en;
	core_pkg::beatmap_word_t beatmap_data;
	core_pkg::timing_addr_t  timing_addr;
	logic                    timing_en;
	core_pkg::timing_word_t  timing_data;
	core_pkg::sample_t       song_data;
	logic                    song_data_ready;
	logic                    song_request;
	core_pkg::sample_t       audio_sample;
	logic                    audio_en;
	logic                    update_tick;
	core_pkg::section_map_t  section_map;
	core_pkg::timing_info_t  timing_info;
	core_pkg::core_state_t   state;

	core_pkg::beatmap_word_t beatmap_mem [0:8191];
	core_pkg::timing_word_t  timing_mem [0:4095];
	core_pkg::beatmap_addr_t exp_size [`CORE_SECTION_COUNT];
	core_pkg::beatmap_addr_t exp_base [`CORE_SECTION_COUNT];
	logic [31:0]             timing_word0;
	logic [31:0]             timing_word1;

	logic [15:0]             lfsr;
	int                      cycle_count = 0;
	int                      play_cycle = 0;
	int                      last_update = 0;
	int                      last_request = 0;
	int                      update_count = 0;
	int                      request_count = 0;
	int                      samples_checked = 0;
	logic                    ready_q = 1'b0;
	core_pkg::sample_t       sent_q;
	logic                    bm_en_q;
	core_pkg::beatmap_addr_t bm_addr_q;
	logic                    tm_en_q;
	core_pkg::timing_addr_t  tm_addr_q;

	core_top dut (.*);

	always #10 CLK = ~CLK;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
	endtask

	task automatic stop_with_failure();
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic expect_eq(input string test_name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("Fail %s: expected %0h, actual %0h", test_name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic build_memories();
		logic [31:0]             bits;
		logic [31:0]             junk;
		core_pkg::beatmap_addr_t addr;
		for (int a = 0; a < 8192; a++) begin
			beatmap_mem[a] = {a[12:0], 11'h2a5};
		end
		for (int a = 0; a < 4096; a++) begin
			timing_mem[a] = {a[11:0], 20'hb7e15};
		end
		for (int i = 0; i < `CORE_SECTION_COUNT; i++) begin
			draw_bits(5, bits);
			draw_bits(11, junk); // upper bits must be ignored
			exp_size[i] = core_pkg::beatmap_addr_t'(bits % 30 + 1);
			if (i == 0) begin
				addr        = '0;
				exp_base[i] = 13'd1;
			end else begin
				addr        = exp_base[i-1] + exp_size[i-1]; // size word ends previous section
				exp_base[i] = exp_base[i-1] + exp_size[i-1] + 1'b1;
			end
			beatmap_mem[addr] = {junk[10:0], exp_size[i]};
		end
		draw_bits(32, timing_word0);
		draw_bits(32, timing_word1);
		timing_mem[0] = timing_word0;
		timing_mem[1] = timing_word1;
	endtask

	// registered reads, data one cycle after the enabled address
	always @(negedge CLK) begin
		bm_en_q   = beatmap_en;
		bm_addr_q = beatmap_addr;
		tm_en_q   = timing_en;
		tm_addr_q = timing_addr;
		@(posedge CLK);
		#2;
		if (bm_en_q) beatmap_data = beatmap_mem[bm_addr_q];
		if (tm_en_q) timing_data = timing_mem[tm_addr_q];
	end

	// song loader restart
	always @(negedge CLK) begin
		logic [31:0] bits;
		if (song_restart) begin
			draw_bits(4, bits);
			repeat (LOADER_MIN_DELAY + int'(bits[3:0])) @(posedge CLK);
			#2 song_reset_done = 1'b1;
			@(posedge CLK);
			#2 song_reset_done = 1'b0;
		end
	end

	// one sample per request, a cycle later
	always @(negedge CLK) begin
		logic [31:0] bits;
		if (song_request) begin
			draw_bits(8, bits);
			@(posedge CLK);
			#2;
			song_data       = bits[7:0];
			song_data_ready = 1'b1;
			@(posedge CLK);
			#2 song_data_ready = 1'b0;
		end
	end

	always @(negedge CLK) begin
		if (ready_q) begin
			expect_eq("audio sample", sent_q, audio_sample);
			samples_checked++;
		end
		ready_q = song_data_ready;
		sent_q  = song_data;
	end

	// tick and request spacing, counted in playing cycles
	always @(negedge CLK) begin
		if (RESET_L && audio_en) begin
			if (update_tick) begin
				if (update_count == 0)
					expect_eq("first update tick", `CORE_UPDATE_PERIOD - 1, play_cycle);
				else
					expect_eq("update tick spacing", `CORE_UPDATE_PERIOD,
						play_cycle - last_update);
				last_update = play_cycle;
				update_count++;
			end
			if (song_request) begin
				if (request_count == 0)
					expect_eq("first song request", FIRST_REQUEST, play_cycle);
				else
					expect_eq("song request spacing", `CORE_AUDIO_PERIOD,
						play_cycle - last_request);
				last_request = play_cycle;
				request_count++;
			end
			play_cycle++;
		end
	end

	reset_values: assert property (@(posedge CLK) !RESET_L |=> (!song_restart
		&& !song_request && !update_tick && !audio_en && !beatmap_en && !timing_en
		&& state == core_pkg::st_init && audio_sample == '0))
	else begin
		$display("outputs were not at their reset values after a reset cycle");
		stop_with_failure();
	end

	hold_song_reset: assert property (@(posedge CLK) disable iff (!RESET_L)
		(state == core_pkg::st_w_song_reset && !song_reset_done)
		|=> state == core_pkg::st_w_song_reset)
	else begin
		$display("the sequencer left the song reset wait before the loader was done");
		stop_with_failure();
	end

	quiet_before_play: assert property (@(posedge CLK) disable iff (!RESET_L)
		!audio_en |-> (!update_tick && !song_request))
	else begin
		$display("update tick or song request seen before playing started");
		stop_with_failure();
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout, the core did not reach the end of its tests in %0d cycles",
				TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	initial begin
		CLK             = 1'b0;
		RESET_L         = 1'b0;
		song_reset_done = 1'b0;
		beatmap_data    = '0;
		timing_data     = '0;
		song_data       = '0;
		song_data_ready = 1'b0;
		lfsr            = 16'd42;
		build_memories();

		repeat (16) @(posedge CLK);
		#1;
		expect_eq("reset state", core_pkg::st_init, state);
		#1 RESET_L = 1'b1;

		while (state !== core_pkg::st_read_timing) @(negedge CLK);
		for (int i = 0; i < `CORE_SECTION_COUNT; i++) begin
			expect_eq($sformatf("section %0d size", i), exp_size[i], section_map.size[i]);
			expect_eq($sformatf("section %0d base", i), exp_base[i], section_map.base[i]);
		end

		while (audio_en !== 1'b1) @(negedge CLK);
		expect_eq("timing table size", timing_word0[11:0], timing_info.table_size);
		expect_eq("song length", timing_word1[19:0], timing_info.song_length);

		while (samples_checked < SAMPLES_TO_CHECK || update_count < UPDATES_TO_SEE)
			@(negedge CLK);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: hw/beatmap_index_scanner.sv
// beatmap_index_scanner: reads section size words and builds the section base map
`include "core_defines.svh"

module beatmap_index_scanner (
	input  logic                    CLK,
	input  logic                    RESET_L,

	input  logic                    scan_start,
	output logic                    scan_done,

	output core_pkg::beatmap_addr_t beatmap_addr,
	output logic                    beatmap_en,
	input  core_pkg::beatmap_word_t beatmap_data,

	output core_pkg::section_map_t  section_map
);

	localparam int SEC_W  = $clog2(`CORE_SECTION_COUNT);
	localparam int SLOT_W = $clog2(`CORE_INDEX_READ_SLOTS);

	localparam logic [SEC_W-1:0]  LAST_SEC  = SEC_W'(`CORE_SECTION_COUNT - 1);
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`CORE_INDEX_READ_SLOTS - 1);

	logic                    busy;
	logic [SEC_W-1:0]        sec;
	logic [SLOT_W-1:0]       slot;
	core_pkg::beatmap_addr_t next_addr; // where the next size word sits
	core_pkg::beatmap_addr_t data_size;

	// only the low bits of the word hold the size
	assign data_size = core_pkg::beatmap_addr_t'(beatmap_data);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			busy       <= 1'b0;
			sec        <= '0;
			slot       <= '0;
			beatmap_en <= 1'b0;
			scan_done  <= 1'b0;
		end else begin
			scan_done <= 1'b0;
			if (!busy) begin
				if (scan_start) begin // setup cycle
					busy <= 1'b1;
					sec  <= '0;
					slot <= '0;
				end
			end else begin
				slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
				if (slot == '0) begin
					beatmap_en <= 1'b1;
				end else if (slot == LAST_SLOT) begin
					beatmap_en <= 1'b0;
					if (sec == LAST_SEC) begin
						busy      <= 1'b0;
						sec       <= '0;
						scan_done <= 1'b1; // right after the last capture
					end else begin
						sec <= sec + 1'b1;
					end
				end
			end
		end
	end

	// address and map registers
	always_ff @(posedge CLK) begin
		if (!busy && scan_start) begin
			next_addr <= '0; // section 0 size word
		end
		if (busy && slot == '0) begin
			beatmap_addr <= next_addr;
		end
		if (busy && slot == LAST_SLOT) begin
			section_map.size[sec] <= data_size;
			section_map.base[sec] <= next_addr + 1'b1; // notes follow the size word
			next_addr             <= next_addr + data_size + 1'b1;
		end
	end

endmodule

// File: hw/core_defines.svh
// playback periods, start delay, section count and index table read geometry
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// system clocks per game-update tick
`define CORE_UPDATE_PERIOD 10

// system clocks per audio-sample tick
`define CORE_AUDIO_PERIOD 4

// audio ticks held back before the first song sample request
`define CORE_PLAY_DELAY 6

// difficulty sections in the beatmap index table
`define CORE_SECTION_COUNT 4

// cycles per table read
// slot 0 drives the address, the last slot captures the data,
// so a read port has two cycles to answer
`define CORE_INDEX_READ_SLOTS 4

// on silicon the periods come from the system clock:
// update at 1 kHz, audio at 44.1 kHz, delay of 1.5 s of samples.
// the values above are kept short so a simulation reaches playback
// within a few hundred cycles

`endif

// File: hw/core_pkg.sv
// core_pkg: width typedefs, sequencer state enum, section map and timing info structs
`include "core_defines.svh"

package core_pkg;

	// beatmap memory, address also used as section size
	typedef logic [12:0] beatmap_addr_t;
	typedef logic [23:0] beatmap_word_t;

	// timing memory, address also used as table size
	typedef logic [11:0] timing_addr_t;
	typedef logic [31:0] timing_word_t;

	typedef logic [19:0] song_length_t;
	typedef logic [7:0]  sample_t;

	// boot phases, each a one-cycle start state and a wait state
	typedef enum logic [2:0] {
		st_init,
		st_song_reset,
		st_w_song_reset,
		st_scan_index,
		st_w_scan_index,
		st_read_timing,
		st_w_read_timing,
		st_playing
	} core_state_t;

	// per-section size and first note address
	typedef struct packed {
		beatmap_addr_t [`CORE_SECTION_COUNT-1:0] size;
		beatmap_addr_t [`CORE_SECTION_COUNT-1:0] base;
	} section_map_t;

	// timing header contents
	typedef struct packed {
		timing_addr_t table_size;
		song_length_t song_length;
	} timing_info_t;

endpackage

// File: hw/core_sequencer.sv
// core_sequencer: boot and playing FSM with start strobes and playing level
module core_sequencer (
	input  logic                 CLK,
	input  logic                 RESET_L,

	input  logic                 song_reset_done,
	input  logic                 scan_done,
	input  logic                 timing_done,

	output logic                 song_restart,
	output logic                 scan_start,
	output logic                 timing_start,
	output logic                 playing,

	output core_pkg::core_state_t state
);

	core_pkg::core_state_t next_state;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state <= core_pkg::st_init;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			core_pkg::st_init: begin
				next_state = core_pkg::st_song_reset;
			end
			core_pkg::st_song_reset: begin
				next_state = core_pkg::st_w_song_reset;
			end
			core_pkg::st_w_song_reset: begin
				if (song_reset_done) begin
					next_state = core_pkg::st_scan_index;
				end
			end
			core_pkg::st_scan_index: begin
				next_state = core_pkg::st_w_scan_index;
			end
			core_pkg::st_w_scan_index: begin
				if (scan_done) begin
					next_state = core_pkg::st_read_timing;
				end
			end
			core_pkg::st_read_timing: begin
				next_state = core_pkg::st_w_read_timing;
			end
			core_pkg::st_w_read_timing: begin
				if (timing_done) begin
					next_state = core_pkg::st_playing;
				end
			end
			core_pkg::st_playing: begin
				next_state = core_pkg::st_playing; // game runs until reset
			end
			default: begin
				next_state = core_pkg::st_init;
			end
		endcase
	end

	// one-cycle strobes, one per start state
	assign song_restart = (state == core_pkg::st_song_reset);
	assign scan_start   = (state == core_pkg::st_scan_index);
	assign timing_start = (state == core_pkg::st_read_timing);

	// level, stays up once reached
	assign playing = (state == core_pkg::st_playing);

endmodule

// File: hw/core_top.sv
// core_top: sequencer, beatmap index scanner, timing header reader and playback clock
module core_top (
	input  logic                    CLK,
	input  logic                    RESET_L,

	input  logic                    song_reset_done,
	output logic                    song_restart,

	output core_pkg::beatmap_addr_t beatmap_addr,
	output logic                    beatmap_en,
	input  core_pkg::beatmap_word_t beatmap_data,

	output core_pkg::timing_addr_t  timing_addr,
	output logic                    timing_en,
	input  core_pkg::timing_word_t  timing_data,

	input  core_pkg::sample_t       song_data,
	input  logic                    song_data_ready,
	output logic                    song_request,
	output core_pkg::sample_t       audio_sample,
	output logic                    audio_en,
	output logic                    update_tick,

	output core_pkg::section_map_t  section_map,
	output core_pkg::timing_info_t  timing_info,
	output core_pkg::core_state_t   state
);

	logic scan_start;
	logic scan_done;
	logic timing_start;
	logic timing_done;

	core_sequencer u_sequencer (
		.CLK             (CLK),
		.RESET_L         (RESET_L),
		.song_reset_done (song_reset_done),
		.scan_done       (scan_done),
		.timing_done     (timing_done),
		.song_restart    (song_restart),
		.scan_start      (scan_start),
		.timing_start    (timing_start),
		.playing         (audio_en),
		.state           (state)
	);

	beatmap_index_scanner u_scanner (
		.CLK          (CLK),
		.RESET_L      (RESET_L),
		.scan_start   (scan_start),
		.scan_done    (scan_done),
		.beatmap_addr (beatmap_addr),
		.beatmap_en   (beatmap_en),
		.beatmap_data (beatmap_data),
		.section_map  (section_map)
	);

	timing_header_reader u_timing (
		.CLK          (CLK),
		.RESET_L      (RESET_L),
		.timing_start (timing_start),
		.timing_done  (timing_done),
		.timing_addr  (timing_addr),
		.timing_en    (timing_en),
		.timing_data  (timing_data),
		.timing_info  (timing_info)
	);

	playback_clock u_playback (
		.CLK             (CLK),
		.RESET_L         (RESET_L),
		.playing         (audio_en),
		.song_data       (song_data),
		.song_data_ready (song_data_ready),
		.update_tick     (update_tick),
		.song_request    (song_request),
		.audio_sample    (audio_sample)
	);

endmodule

// File: hw/playback_clock.sv
// playback_clock: update and audio dividers, start delay, sample requests, sample latch
`include "core_defines.svh"

module playback_clock (
	input  logic              CLK,
	input  logic              RESET_L,

	input  logic              playing,

	input  core_pkg::sample_t song_data,
	input  logic              song_data_ready,

	output logic              update_tick,
	output logic              song_request,
	output core_pkg::sample_t audio_sample
);

	localparam int UPD_W = $clog2(`CORE_UPDATE_PERIOD);
	localparam int AUD_W = $clog2(`CORE_AUDIO_PERIOD);
	localparam int DLY_W = $clog2(`CORE_PLAY_DELAY + 1);

	localparam logic [UPD_W-1:0] UPD_LAST = UPD_W'(`CORE_UPDATE_PERIOD - 1);
	localparam logic [AUD_W-1:0] AUD_LAST = AUD_W'(`CORE_AUDIO_PERIOD - 1);
	localparam logic [DLY_W-1:0] DLY_FULL = DLY_W'(`CORE_PLAY_DELAY);

	logic [UPD_W-1:0] update_cnt;
	logic [AUD_W-1:0] audio_cnt;
	logic [DLY_W-1:0] delay_cnt;
	logic             audio_tick;

	assign update_tick = playing && (update_cnt == UPD_LAST);
	assign audio_tick  = playing && (audio_cnt == AUD_LAST);

	// both dividers run only in the playing state
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			update_cnt <= '0;
			audio_cnt  <= '0;
		end else if (playing) begin
			update_cnt <= (update_cnt == UPD_LAST) ? '0 : update_cnt + 1'b1;
			audio_cnt  <= (audio_cnt == AUD_LAST) ? '0 : audio_cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			delay_cnt    <= '0;
			song_request <= 1'b0;
		end else begin
			if (audio_tick && delay_cnt != DLY_FULL) begin
				delay_cnt <= delay_cnt + 1'b1; // saturates at full delay
			end
			song_request <= audio_tick && (delay_cnt == DLY_FULL);
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			audio_sample <= '0;
		end else if (song_data_ready) begin
			audio_sample <= song_data;
		end
	end

endmodule

// File: hw/timing_header_reader.sv
// timing_header_reader: reads the timing table size and song length words
`include "core_defines.svh"

module timing_header_reader (
	input  logic                   CLK,
	input  logic                   RESET_L,

	input  logic                   timing_start,
	output logic                   timing_done,

	output core_pkg::timing_addr_t timing_addr,
	output logic                   timing_en,
	input  core_pkg::timing_word_t timing_data,

	output core_pkg::timing_info_t timing_info
);

	localparam int SLOT_W = $clog2(`CORE_INDEX_READ_SLOTS);
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`CORE_INDEX_READ_SLOTS - 1);

	logic              busy;
	logic              word_idx; // 0 table size, 1 song length
	logic [SLOT_W-1:0] slot;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			busy        <= 1'b0;
			word_idx    <= 1'b0;
			slot        <= '0;
			timing_en   <= 1'b0;
			timing_done <= 1'b0;
		end else begin
			timing_done <= 1'b0;
			if (!busy) begin
				if (timing_start) begin
					busy     <= 1'b1;
					word_idx <= 1'b0;
					slot     <= '0;
				end
			end else begin
				slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
				if (slot == '0) begin
					timing_en <= 1'b1;
				end else if (slot == LAST_SLOT) begin
					timing_en <= 1'b0;
					word_idx  <= ~word_idx;
					if (word_idx) begin
						busy        <= 1'b0;
						timing_done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (busy && slot == '0) begin
			timing_addr <= core_pkg::timing_addr_t'(word_idx);
		end
		if (busy && slot == LAST_SLOT) begin
			if (word_idx) begin
				timing_info.song_length <= core_pkg::song_length_t'(timing_data);
			end else begin
				timing_info.table_size <= core_pkg::timing_addr_t'(timing_data);
			end
		end
	end

endmodule

// File: list.f
+incdir+hw
hw/core_pkg.sv
hw/core_sequencer.sv
hw/beatmap_index_scanner.sv
hw/timing_header_reader.sv
hw/playback_clock.sv
hw/core_top.sv
dv/core_tb.sv
